//--- ddr_pkg.sv
`default_nettype none

package ddr_pkg;

  // Word address is {bank, row, column}
  localparam int DDR_BANK_BITS = 3;
  localparam int DDR_ROW_BITS = 11;
  localparam int DDR_COL_BITS = 10;

  // One controller word, split by the PHY into a 16-bit burst
  localparam int DDR_DATA_BITS = 32;

  // A10 on PRE selects all banks
  localparam int DDR_ALL_BANKS_BIT = 10;

  // Encoded as {cs_n, ras_n, cas_n, we_n}
  typedef enum logic [3:0] {
    NOP = 4'b0111,
    ACT = 4'b0011,
    RD  = 4'b0101,
    WR  = 4'b0100,
    PRE = 4'b0010,
    REF = 4'b0001,
    MRS = 4'b0000
  } ddr_cmd_e;

  // One DFI command slot, 18 bits
  typedef struct packed {
    ddr_cmd_e                 cmd;
    logic [DDR_BANK_BITS-1:0] bank;
    logic [DDR_ROW_BITS-1:0]  addr;
  } dfi_cmd_t;

endpackage

`default_nettype wire

//--- memreq_pkg.sv
`default_nettype none

package memreq_pkg;

  localparam int MEM_ADDR_BITS = 24;
  localparam int MEM_DATA_BITS = 32;

  // First byte of each host packet
  typedef enum logic [7:0] {
    OP_WRITE = 8'h01,
    OP_READ  = 8'h02
  } mem_op_e;

  // Single-word request to the controller, 57 bits
  typedef struct packed {
    logic                     write;
    logic [MEM_ADDR_BITS-1:0] addr;
    logic [MEM_DATA_BITS-1:0] wdata;
  } mem_req_t;

  // Status byte for an unknown opcode
  localparam logic [7:0] RSP_BAD = 8'hFF;

endpackage

`default_nettype wire

//--- memreq.sv
`timescale 1ns/1ps
`default_nettype none

module memreq
  import memreq_pkg::*;
(
  input  wire logic                     mclk,
  input  wire logic                     arst_n,
  input  wire logic                     configured_i,

  // Host packets in
  input  wire logic                     s_tvalid_i,
  output logic                          s_tready_o,
  input  wire logic                     s_tlast_i,
  input  wire logic [7:0]               s_tdata_i,

  // Response bytes out
  output logic                          m_tvalid_o,
  input  wire logic                     m_tready_i,
  output logic                          m_tlast_o,
  output logic [7:0]                    m_tdata_o,

  // Controller side
  output logic                          req_valid_o,
  output mem_req_t                      req_o,
  input  wire logic                     req_ready_i,
  input  wire logic                     rsp_valid_i,
  input  wire logic [MEM_DATA_BITS-1:0] rsp_rdata_i
);

  typedef enum logic [2:0] {
    S_OPCODE,
    S_ADDR,
    S_DATA,
    S_DRAIN,
    S_REQ,
    S_WAIT,
    S_SEND
  } state_e;

  localparam logic [7:0] RSP_ACK = 8'h01;

  state_e                   state_q;
  mem_req_t                 req_q;
  logic [1:0]               byte_cnt_q;
  logic [MEM_DATA_BITS-1:0] out_q;
  logic [1:0]               out_cnt_q;
  logic                     s_fire;
  logic                     m_fire;
  mem_op_e                  op;

  assign op = mem_op_e'(s_tdata_i);
  assign s_fire = s_tvalid_i && s_tready_o;
  assign m_fire = m_tvalid_o && m_tready_i;

  // Bytes are taken only while parsing, and not before DRAM init
  assign s_tready_o = configured_i && (state_q inside {S_OPCODE, S_ADDR, S_DATA, S_DRAIN});

  assign m_tvalid_o = (state_q == S_SEND);
  assign m_tdata_o = out_q[7:0];
  assign m_tlast_o = (out_cnt_q == 2'd0);

  assign req_valid_o = (state_q == S_REQ);
  assign req_o = req_q;

  always_ff @(posedge mclk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= S_OPCODE;
      byte_cnt_q <= '0;
      out_cnt_q <= '0;
    end else begin
      case (state_q)
        S_OPCODE: begin
          if (s_fire) begin
            byte_cnt_q <= '0;
            case (op)
              OP_WRITE, OP_READ: state_q <= S_ADDR;
              default: begin
                // Unknown opcode, skip the rest of the packet then report
                out_cnt_q <= 2'd0;
                state_q <= s_tlast_i ? S_SEND : S_DRAIN;
              end
            endcase
          end
        end
        S_ADDR: begin
          if (s_fire) begin
            byte_cnt_q <= byte_cnt_q + 2'd1;
            if (byte_cnt_q == 2'd2) begin
              byte_cnt_q <= '0;
              state_q <= req_q.write ? S_DATA : S_REQ;
            end
          end
        end
        S_DATA: begin
          if (s_fire) begin
            byte_cnt_q <= byte_cnt_q + 2'd1;
            if (byte_cnt_q == 2'd3) begin
              state_q <= S_REQ;
            end
          end
        end
        S_DRAIN: begin
          if (s_fire && s_tlast_i) begin
            state_q <= S_SEND;
          end
        end
        S_REQ: begin
          if (req_ready_i) begin
            state_q <= S_WAIT;
          end
        end
        S_WAIT: begin
          if (rsp_valid_i) begin
            out_cnt_q <= req_q.write ? 2'd0 : 2'd3;
            state_q <= S_SEND;
          end
        end
        S_SEND: begin
          if (m_fire) begin
            out_cnt_q <= out_cnt_q - 2'd1;
            if (out_cnt_q == 2'd0) begin
              state_q <= S_OPCODE;
            end
          end
        end
        default: state_q <= S_OPCODE;
      endcase
    end
  end

  // Packet fields and the outgoing shift register
  always_ff @(posedge mclk) begin
    if (s_fire) begin
      case (state_q)
        S_OPCODE: begin
          req_q.write <= (op == OP_WRITE);
          out_q <= MEM_DATA_BITS'(RSP_BAD);
        end
        // Address arrives most significant byte first
        S_ADDR: req_q.addr <= {req_q.addr[MEM_ADDR_BITS-9:0], s_tdata_i};
        // Write data arrives least significant byte first
        S_DATA: req_q.wdata <= {s_tdata_i, req_q.wdata[MEM_DATA_BITS-1:8]};
        default: ;
      endcase
    end
    if (state_q == S_WAIT && rsp_valid_i) begin
      out_q <= req_q.write ? MEM_DATA_BITS'(RSP_ACK) : rsp_rdata_i;
    end else if (m_fire) begin
      out_q <= out_q >> 8;
    end
  end

endmodule

`default_nettype wire

//--- ddr3_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module ddr3_ctrl
  import ddr_pkg::*;
  import memreq_pkg::*;
#(
  parameter int DDR_CL = 6,
  parameter int T_RCD = 3,
  parameter int T_RP = 3,
  parameter int T_REFI = 200,
  parameter int INIT_CYCLES = 20
) (
  input  wire logic                     mclk,
  input  wire logic                     arst_n,
  output logic                          configured_o,

  // Request from the front end
  input  wire logic                     req_valid_i,
  input  wire mem_req_t                 req_i,
  output logic                          req_ready_o,
  output logic                          rsp_valid_o,
  output logic [MEM_DATA_BITS-1:0]      rsp_rdata_o,

  // DFI toward the PHY
  output dfi_cmd_t                      dfi_cmd_o,
  output logic [DDR_DATA_BITS-1:0]      dfi_wdata_o,
  input  wire logic                     dfi_rvld_i,
  input  wire logic [DDR_DATA_BITS-1:0] dfi_rdata_i
);

  typedef enum logic [2:0] {
    S_POWERUP,
    S_INIT_RP,
    S_MODE,
    S_IDLE,
    S_RCD,
    S_WRITE,
    S_READ,
    S_RP
  } state_e;

  localparam int WAIT_BITS = $clog2(INIT_CYCLES + T_RCD + T_RP);
  localparam int REF_BITS = $clog2(T_REFI + 1);
  localparam int ROW_LSB = DDR_COL_BITS;
  localparam int BANK_LSB = DDR_COL_BITS + DDR_ROW_BITS;

  // MR0 with BL8 and the CAS latency field in A6..A4
  localparam logic [DDR_ROW_BITS-1:0] MR0_VALUE = DDR_ROW_BITS'((DDR_CL - 4) << 4);
  localparam logic [DDR_ROW_BITS-1:0] ADDR_ALL_BANKS = DDR_ROW_BITS'(1) << DDR_ALL_BANKS_BIT;

  state_e                   state_q;
  logic [WAIT_BITS-1:0]     wait_q;
  logic                     wait_done;
  logic [REF_BITS-1:0]      ref_cnt_q;
  logic                     ref_pending_q;
  logic                     ref_tick;
  logic                     ref_issue;
  logic                     req_fire;
  logic                     close_page;
  mem_req_t                 cur_q;
  logic [DDR_BANK_BITS-1:0] req_bank;
  logic [DDR_ROW_BITS-1:0]  req_row;
  logic [DDR_BANK_BITS-1:0] cur_bank;
  logic [DDR_COL_BITS-1:0]  cur_col;

  function automatic dfi_cmd_t make_cmd(ddr_cmd_e cmd, logic [DDR_BANK_BITS-1:0] bank,
                                        logic [DDR_ROW_BITS-1:0] addr);
    return '{cmd: cmd, bank: bank, addr: addr};
  endfunction

  assign req_bank = req_i.addr[BANK_LSB +: DDR_BANK_BITS];
  assign req_row = req_i.addr[ROW_LSB +: DDR_ROW_BITS];
  assign cur_bank = cur_q.addr[BANK_LSB +: DDR_BANK_BITS];
  assign cur_col = cur_q.addr[0 +: DDR_COL_BITS];

  assign wait_done = (wait_q == '0);
  assign ref_tick = configured_o && (ref_cnt_q == REF_BITS'(T_REFI - 1));
  assign ref_issue = (state_q == S_IDLE) && ref_pending_q;

  // A pending refresh blocks new requests
  assign req_ready_o = (state_q == S_IDLE) && !ref_pending_q;
  assign req_fire = req_ready_o && req_valid_i;

  // Write closes right after WR, read closes once data is back
  assign close_page = (state_q == S_WRITE) || (state_q == S_READ && dfi_rvld_i);

  assign dfi_wdata_o = cur_q.wdata;

  always_ff @(posedge mclk or negedge arst_n) begin
    if (!arst_n) begin
      ref_cnt_q <= '0;
      ref_pending_q <= 1'b0;
    end else begin
      if (configured_o) begin
        ref_cnt_q <= ref_tick ? '0 : ref_cnt_q + 1'b1;
      end
      if (ref_issue) begin
        ref_pending_q <= 1'b0;
      end
      if (ref_tick) begin
        ref_pending_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge mclk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= S_POWERUP;
      wait_q <= WAIT_BITS'(INIT_CYCLES - 1);
      configured_o <= 1'b0;
      rsp_valid_o <= 1'b0;
      dfi_cmd_o <= make_cmd(NOP, '0, '0);
    end else begin
      dfi_cmd_o <= make_cmd(NOP, '0, '0);
      rsp_valid_o <= 1'b0;
      if (!wait_done) begin
        wait_q <= wait_q - 1'b1;
      end

      case (state_q)
        S_POWERUP: begin
          if (wait_done) begin
            dfi_cmd_o <= make_cmd(PRE, '0, ADDR_ALL_BANKS);
            wait_q <= WAIT_BITS'(T_RP - 1);
            state_q <= S_INIT_RP;
          end
        end
        S_INIT_RP: begin
          if (wait_done) begin
            dfi_cmd_o <= make_cmd(MRS, '0, MR0_VALUE);
            state_q <= S_MODE;
          end
        end
        S_MODE: begin
          configured_o <= 1'b1;
          state_q <= S_IDLE;
        end
        S_IDLE: begin
          if (ref_issue) begin
            dfi_cmd_o <= make_cmd(REF, '0, '0);
            wait_q <= WAIT_BITS'(T_RP - 1);
            state_q <= S_RP;
          end else if (req_fire) begin
            dfi_cmd_o <= make_cmd(ACT, req_bank, req_row);
            wait_q <= WAIT_BITS'(T_RCD - 1);
            state_q <= S_RCD;
          end
        end
        S_RCD: begin
          if (wait_done) begin
            dfi_cmd_o <= make_cmd(cur_q.write ? WR : RD, cur_bank, DDR_ROW_BITS'(cur_col));
            state_q <= cur_q.write ? S_WRITE : S_READ;
          end
        end
        S_WRITE, S_READ: begin
          if (close_page) begin
            dfi_cmd_o <= make_cmd(PRE, cur_bank, '0);
            rsp_valid_o <= 1'b1;
            wait_q <= WAIT_BITS'(T_RP - 1);
            state_q <= S_RP;
          end
        end
        // Shared by precharge and refresh recovery
        S_RP: begin
          if (wait_done) begin
            state_q <= S_IDLE;
          end
        end
        default: state_q <= S_POWERUP;
      endcase
    end
  end

  always_ff @(posedge mclk) begin
    if (req_fire) begin
      cur_q <= req_i;
    end
    if (state_q == S_READ && dfi_rvld_i) begin
      rsp_rdata_o <= dfi_rdata_i;
    end
  end

endmodule

`default_nettype wire

//--- ddr3_top.sv
`timescale 1ns/1ps
`default_nettype none

module ddr3_top
  import ddr_pkg::*;
  import memreq_pkg::*;
#(
  parameter int DDR_CL = 6,
  parameter int T_RCD = 3,
  parameter int T_RP = 3,
  parameter int T_REFI = 200,
  parameter int INIT_CYCLES = 20
) (
  input  wire logic                     mclk,
  input  wire logic                     arst_n,
  output logic                          configured_o,

  // Host byte streams
  input  wire logic                     s_tvalid_i,
  output logic                          s_tready_o,
  input  wire logic                     s_tlast_i,
  input  wire logic [7:0]               s_tdata_i,
  output logic                          m_tvalid_o,
  input  wire logic                     m_tready_i,
  output logic                          m_tlast_o,
  output logic [7:0]                    m_tdata_o,

  // DFI boundary
  output dfi_cmd_t                      dfi_cmd_o,
  output logic [DDR_DATA_BITS-1:0]      dfi_wdata_o,
  input  wire logic                     dfi_rvld_i,
  input  wire logic [DDR_DATA_BITS-1:0] dfi_rdata_i
);

  logic                     req_valid;
  logic                     req_ready;
  mem_req_t                 req;
  logic                     rsp_valid;
  logic [MEM_DATA_BITS-1:0] rsp_rdata;

  memreq memreq_inst (
    .mclk         (mclk),
    .arst_n       (arst_n),
    .configured_i (configured_o),
    .s_tvalid_i   (s_tvalid_i),
    .s_tready_o   (s_tready_o),
    .s_tlast_i    (s_tlast_i),
    .s_tdata_i    (s_tdata_i),
    .m_tvalid_o   (m_tvalid_o),
    .m_tready_i   (m_tready_i),
    .m_tlast_o    (m_tlast_o),
    .m_tdata_o    (m_tdata_o),
    .req_valid_o  (req_valid),
    .req_o        (req),
    .req_ready_i  (req_ready),
    .rsp_valid_i  (rsp_valid),
    .rsp_rdata_i  (rsp_rdata)
  );

  ddr3_ctrl #(
    .DDR_CL      (DDR_CL),
    .T_RCD       (T_RCD),
    .T_RP        (T_RP),
    .T_REFI      (T_REFI),
    .INIT_CYCLES (INIT_CYCLES)
  ) ddr3_ctrl_inst (
    .mclk         (mclk),
    .arst_n       (arst_n),
    .configured_o (configured_o),
    .req_valid_i  (req_valid),
    .req_i        (req),
    .req_ready_o  (req_ready),
    .rsp_valid_o  (rsp_valid),
    .rsp_rdata_o  (rsp_rdata),
    .dfi_cmd_o    (dfi_cmd_o),
    .dfi_wdata_o  (dfi_wdata_o),
    .dfi_rvld_i   (dfi_rvld_i),
    .dfi_rdata_i  (dfi_rdata_i)
  );

endmodule

`default_nettype wire

//--- ddr3_dram_model.sv
`timescale 1ns/1ps
`default_nettype none

module ddr3_dram_model
  import ddr_pkg::*;
#(
  parameter int DDR_CL = 6
) (
  input  wire logic                        mclk,
  input  wire logic                        arst_n,
  input  wire dfi_cmd_t                    dfi_cmd_i,
  input  wire logic [DDR_DATA_BITS-1:0]    dfi_wdata_i,
  output logic                             dfi_rvld_o,
  output logic [DDR_DATA_BITS-1:0]         dfi_rdata_o,
  output logic [2**DDR_BANK_BITS-1:0]      rows_open_o
);

  localparam int ADDR_BITS = DDR_BANK_BITS + DDR_ROW_BITS + DDR_COL_BITS;

  // Sparse storage keyed by {bank, row, column}
  logic [DDR_DATA_BITS-1:0] mem [logic [ADDR_BITS-1:0]];
  logic [DDR_ROW_BITS-1:0]  open_row [2**DDR_BANK_BITS];
  logic [DDR_CL-1:0]        rvld_sr;
  logic [DDR_DATA_BITS-1:0] rdata_sr [DDR_CL];
  logic [ADDR_BITS-1:0]     acc_addr;

  // Unwritten words read back as a pattern built from the address
  function automatic logic [DDR_DATA_BITS-1:0] fill_word(input logic [ADDR_BITS-1:0] addr);
    return {addr[7:0] ^ 8'h5A, addr};
  endfunction

  assign acc_addr = {dfi_cmd_i.bank, open_row[dfi_cmd_i.bank],
                     dfi_cmd_i.addr[DDR_COL_BITS-1:0]};
  assign dfi_rvld_o = rvld_sr[DDR_CL-1];
  assign dfi_rdata_o = rdata_sr[DDR_CL-1];

  always_ff @(posedge mclk or negedge arst_n) begin
    if (!arst_n) begin
      rvld_sr <= '0;
      rows_open_o <= '0;
    end else begin
      rvld_sr <= {rvld_sr[DDR_CL-2:0], dfi_cmd_i.cmd == RD};
      if (dfi_cmd_i.cmd == ACT) begin
        rows_open_o[dfi_cmd_i.bank] <= 1'b1;
      end else if (dfi_cmd_i.cmd == PRE) begin
        if (dfi_cmd_i.addr[DDR_ALL_BANKS_BIT]) begin
          rows_open_o <= '0;
        end else begin
          rows_open_o[dfi_cmd_i.bank] <= 1'b0;
        end
      end
    end
  end

  // Row latch, write storage and read delay line
  always @(posedge mclk) begin
    if (dfi_cmd_i.cmd == ACT) begin
      open_row[dfi_cmd_i.bank] <= dfi_cmd_i.addr;
    end
    if (dfi_cmd_i.cmd == WR) begin
      mem[acc_addr] = dfi_wdata_i;
    end
    rdata_sr[0] <= mem.exists(acc_addr) ? mem[acc_addr] : fill_word(acc_addr);
    for (int i = DDR_CL - 1; i > 0; i--) begin
      rdata_sr[i] <= rdata_sr[i-1];
    end
  end

endmodule

`default_nettype wire

//--- ddr3_ctrl_props.sv
`timescale 1ns/1ps
`default_nettype none

module ddr3_ctrl_props
  import ddr_pkg::*;
#(
  parameter int T_RCD = 3
) (
  input  wire logic     mclk,
  input  wire logic     arst_n,
  input  wire logic     configured_o,
  input  wire logic     rsp_valid_o,
  input  wire dfi_cmd_t dfi_cmd_o
);

  logic       pre_seen_q;
  logic       mrs_seen_q;
  logic       row_open_q;
  logic [7:0] since_act_q;

  always_ff @(posedge mclk or negedge arst_n) begin
    if (!arst_n) begin
      pre_seen_q <= 1'b0;
      mrs_seen_q <= 1'b0;
      row_open_q <= 1'b0;
      since_act_q <= 8'hFF;
    end else begin
      if (!configured_o && dfi_cmd_o.cmd == PRE) begin
        pre_seen_q <= 1'b1;
      end
      if (!configured_o && dfi_cmd_o.cmd == MRS) begin
        mrs_seen_q <= 1'b1;
      end
      if (dfi_cmd_o.cmd == ACT) begin
        row_open_q <= 1'b1;
      end else if (dfi_cmd_o.cmd == PRE) begin
        row_open_q <= 1'b0;
      end
      // Cycles since the last ACT, saturating
      if (dfi_cmd_o.cmd == ACT) begin
        since_act_q <= 8'd1;
      end else if (since_act_q != 8'hFF) begin
        since_act_q <= since_act_q + 8'd1;
      end
    end
  end

  init_quiet: assert property (@(posedge mclk) disable iff (!arst_n)
    !configured_o |-> (dfi_cmd_o.cmd == NOP) ||
      (dfi_cmd_o.cmd == PRE && !pre_seen_q && dfi_cmd_o.addr[DDR_ALL_BANKS_BIT]) ||
      (dfi_cmd_o.cmd == MRS && !mrs_seen_q))
    else $error("unexpected DFI command before configuration");

  rcd_gap: assert property (@(posedge mclk) disable iff (!arst_n)
    (dfi_cmd_o.cmd == RD || dfi_cmd_o.cmd == WR) |-> since_act_q >= 8'(T_RCD))
    else $error("RD or WR issued less than T_RCD cycles after ACT");

  ref_closed: assert property (@(posedge mclk) disable iff (!arst_n)
    (dfi_cmd_o.cmd == REF) |-> !row_open_q)
    else $error("REF issued while a row is open");

  rsp_strobe: assert property (@(posedge mclk) disable iff (!arst_n)
    !(rsp_valid_o && $past(rsp_valid_o)))
    else $error("rsp_valid_o high on two consecutive cycles");

endmodule

bind ddr3_ctrl ddr3_ctrl_props #(
  .T_RCD (T_RCD)
) ddr3_ctrl_props_inst (
  .mclk         (mclk),
  .arst_n       (arst_n),
  .configured_o (configured_o),
  .rsp_valid_o  (rsp_valid_o),
  .dfi_cmd_o    (dfi_cmd_o)
);

`default_nettype wire

//--- tb_ddr3_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ddr3_top
  import ddr_pkg::*;
  import memreq_pkg::*;
();

  localparam int CL = 6;
  localparam int REFI = 200;
  localparam int TEST_COUNT = 6;
  localparam int CYCLES_PER_TEST = 3000;
  localparam int TIMEOUT_CYCLES = TEST_COUNT * CYCLES_PER_TEST + 2000;
  localparam logic [23:0] BASE_ADDR = 24'h5A3C12;
  localparam logic [31:0] BASE_DATA = 32'hDEADBEEF;

  logic        mclk;
  logic        arst_n;
  logic        configured_o;
  logic        s_tvalid_i;
  logic        s_tready_o;
  logic        s_tlast_i;
  logic [7:0]  s_tdata_i;
  logic        m_tvalid_o;
  logic        m_tready_i;
  logic        m_tlast_o;
  logic [7:0]  m_tdata_o;
  dfi_cmd_t    dfi_cmd_o;
  logic [31:0] dfi_wdata_o;
  logic        dfi_rvld_i;
  logic [31:0] dfi_rdata_i;
  logic [7:0]  rows_open;

  int          seed;
  int          err_cnt;
  int          check_cnt;
  int          cycle_cnt;
  int          ref_cnt;
  int          init_seen;
  logic        heavy_bp;
  logic        ref_window;
  logic        hold_q;
  logic        held_last;
  logic [7:0]  held_data;
  dfi_cmd_t    init_cmds [2];
  logic [7:0]  tx_q [$];
  logic [7:0]  rx_data [$];
  logic        rx_last [$];
  logic [31:0] sb [logic [23:0]];

  ddr3_top #(
    .DDR_CL (CL),
    .T_REFI (REFI)
  ) ddr3_top_inst (
    .mclk         (mclk),
    .arst_n       (arst_n),
    .configured_o (configured_o),
    .s_tvalid_i   (s_tvalid_i),
    .s_tready_o   (s_tready_o),
    .s_tlast_i    (s_tlast_i),
    .s_tdata_i    (s_tdata_i),
    .m_tvalid_o   (m_tvalid_o),
    .m_tready_i   (m_tready_i),
    .m_tlast_o    (m_tlast_o),
    .m_tdata_o    (m_tdata_o),
    .dfi_cmd_o    (dfi_cmd_o),
    .dfi_wdata_o  (dfi_wdata_o),
    .dfi_rvld_i   (dfi_rvld_i),
    .dfi_rdata_i  (dfi_rdata_i)
  );

  ddr3_dram_model #(
    .DDR_CL (CL)
  ) dram_model_inst (
    .mclk        (mclk),
    .arst_n      (arst_n),
    .dfi_cmd_i   (dfi_cmd_o),
    .dfi_wdata_i (dfi_wdata_o),
    .dfi_rvld_o  (dfi_rvld_i),
    .dfi_rdata_o (dfi_rdata_i),
    .rows_open_o (rows_open)
  );

  initial begin
    mclk = 1'b0;
    forever #50 mclk = ~mclk;
  end

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    check_cnt++;
    assert (exp === act) else begin
      err_cnt++;
      $display("FAIL %s expected %h actual %h", name, exp, act);
    end
  endtask

  // First two commands after reset, and REF bookkeeping
  always @(posedge mclk) begin
    if (arst_n && dfi_cmd_o.cmd != NOP && init_seen < 2) begin
      init_cmds[init_seen] = dfi_cmd_o;
      init_seen++;
    end
    if (arst_n && dfi_cmd_o.cmd == REF) begin
      if (ref_window) begin
        ref_cnt++;
      end
      check_cnt++;
      assert (rows_open == 8'h00) else begin
        err_cnt++;
        $display("REF issued while the DRAM model still had a row open");
      end
    end
  end

  // Output byte must hold while stalled
  always @(posedge mclk) begin
    if (hold_q) begin
      check_value("m_tvalid_o", 32'(1'b1), 32'(m_tvalid_o));
      check_value("m_tdata_o", 32'(held_data), 32'(m_tdata_o));
      check_value("m_tlast_o", 32'(held_last), 32'(m_tlast_o));
    end
    hold_q = m_tvalid_o && !m_tready_i;
    held_data = m_tdata_o;
    held_last = m_tlast_o;
  end

  task automatic load_packet(input logic [7:0] op, input logic [23:0] addr,
                             input logic [31:0] data, input logic with_data);
    tx_q.delete();
    tx_q.push_back(op);
    tx_q.push_back(addr[23:16]);
    tx_q.push_back(addr[15:8]);
    tx_q.push_back(addr[7:0]);
    if (with_data) begin
      for (int i = 0; i < 4; i++) begin
        tx_q.push_back(data[8*i +: 8]);
      end
    end
  endtask

  task automatic send_packet();
    for (int i = 0; i < tx_q.size(); i++) begin
      @(negedge mclk);
      s_tvalid_i = 1'b1;
      s_tdata_i = tx_q[i];
      s_tlast_i = (i == tx_q.size() - 1);
      @(posedge mclk);
      while (!s_tready_o) begin
        @(posedge mclk);
      end
    end
    @(negedge mclk);
    s_tvalid_i = 1'b0;
    s_tlast_i = 1'b0;
  endtask

  task automatic receive_bytes(input int count);
    logic [31:0] draw;
    rx_data.delete();
    rx_last.delete();
    while (rx_data.size() < count) begin
      @(negedge mclk);
      draw = $random(seed);
      m_tready_i = heavy_bp ? (draw[2:0] == 3'd0) : (draw[1:0] != 2'd0);
      @(posedge mclk);
      if (m_tvalid_o && m_tready_i) begin
        rx_data.push_back(m_tdata_o);
        rx_last.push_back(m_tlast_o);
      end
    end
    @(negedge mclk);
    m_tready_i = 1'b0;
  endtask

  task automatic do_write(input logic [23:0] addr, input logic [31:0] data);
    load_packet(OP_WRITE, addr, data, 1'b1);
    send_packet();
    receive_bytes(1);
    check_value("m_tdata_o", 32'h01, 32'(rx_data[0]));
    check_value("m_tlast_o", 32'(1'b1), 32'(rx_last[0]));
  endtask

  task automatic do_read(input logic [23:0] addr, input logic [31:0] exp);
    load_packet(OP_READ, addr, 32'h0, 1'b0);
    send_packet();
    receive_bytes(4);
    // Least significant byte comes out first
    for (int i = 0; i < 4; i++) begin
      check_value("m_tdata_o", 32'(exp[8*i +: 8]), 32'(rx_data[i]));
      check_value("m_tlast_o", 32'(i == 3), 32'(rx_last[i]));
    end
  endtask

  task automatic test_init();
    @(negedge mclk);
    check_value("configured_o", 32'h0, 32'(configured_o));
    check_value("s_tready_o", 32'h0, 32'(s_tready_o));
    check_value("m_tvalid_o", 32'h0, 32'(m_tvalid_o));
    check_value("dfi_cmd_o.cmd", 32'(NOP), 32'(dfi_cmd_o.cmd));
    while (!configured_o) begin
      @(posedge mclk);
    end
    check_cnt++;
    assert (init_seen == 2) else begin
      err_cnt++;
      $display("Fewer than two commands were issued before configuration");
    end
    check_value("dfi_cmd_o.cmd", 32'(PRE), 32'(init_cmds[0].cmd));
    check_value("dfi_cmd_o.addr[10]", 32'h1, 32'(init_cmds[0].addr[DDR_ALL_BANKS_BIT]));
    check_value("dfi_cmd_o.cmd", 32'(MRS), 32'(init_cmds[1].cmd));
  endtask

  task automatic test_write_read();
    do_write(BASE_ADDR, BASE_DATA);
    do_read(BASE_ADDR, BASE_DATA);
  endtask

  task automatic test_backpressure();
    heavy_bp = 1'b1;
    do_write(24'h2A0155, 32'h0BADF00D);
    do_read(24'h2A0155, 32'h0BADF00D);
    do_read(BASE_ADDR, BASE_DATA);
    heavy_bp = 1'b0;
  endtask

  task automatic test_bad_opcode();
    load_packet(8'h7E, 24'h112233, 32'h0, 1'b0);
    send_packet();
    receive_bytes(1);
    check_value("m_tdata_o", 32'(RSP_BAD), 32'(rx_data[0]));
    check_value("m_tlast_o", 32'(1'b1), 32'(rx_last[0]));
    do_read(BASE_ADDR, BASE_DATA);
  endtask

  task automatic test_refresh();
    ref_cnt = 0;
    ref_window = 1'b1;
    repeat (1000) @(posedge mclk);
    // Window closes between edges so the last edge is always counted
    @(negedge mclk);
    ref_window = 1'b0;
    check_cnt++;
    assert (ref_cnt >= 4 && ref_cnt <= 5) else begin
      err_cnt++;
      $display("FAIL ref_count expected 4..5 actual %h", ref_cnt);
    end
  endtask

  task automatic test_random_traffic();
    logic [23:0] pool [8];
    logic [31:0] draw;
    logic [31:0] wdata;
    logic [23:0] addr;
    // One address per bank, each on a random row
    for (int b = 0; b < 8; b++) begin
      draw = $random(seed);
      pool[b] = {3'(b), draw[20:10], draw[9:0]};
    end
    for (int n = 0; n < 40; n++) begin
      draw = $random(seed);
      addr = pool[draw[2:0]];
      if (draw[3] && sb.exists(addr)) begin
        do_read(addr, sb[addr]);
      end else begin
        wdata = $random(seed);
        sb[addr] = wdata;
        do_write(addr, wdata);
      end
    end
  endtask

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge mclk);
      cycle_cnt++;
    end
    $display("Timeout: run exceeded %0d cycles", TIMEOUT_CYCLES);
    $display("tests failed");
    $finish;
  end

  initial begin
    seed = 32'he2d;
    err_cnt = 0;
    check_cnt = 0;
    init_seen = 0;
    ref_cnt = 0;
    heavy_bp = 1'b0;
    ref_window = 1'b0;
    hold_q = 1'b0;
    arst_n = 1'b0;
    s_tvalid_i = 1'b0;
    s_tlast_i = 1'b0;
    s_tdata_i = 8'h00;
    m_tready_i = 1'b0;
    repeat (3) @(posedge mclk);
    @(negedge mclk);
    arst_n = 1'b1;

    test_init();
    test_write_read();
    test_backpressure();
    test_bad_opcode();
    test_refresh();
    test_random_traffic();

    $display("Checks run: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
ddr_pkg.sv
memreq_pkg.sv
memreq.sv
ddr3_ctrl.sv
ddr3_top.sv
ddr3_dram_model.sv
ddr3_ctrl_props.sv
tb_ddr3_top.sv

//--- run.sh
#!/bin/sh
# Build and run the DDR3 subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module tb_ddr3_top -o sim_tb
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "tests failed" sim.log; then
  echo "Result: FAIL"
  exit 1
fi

echo "Result: PASS"
exit 0
